// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module mpu_periph_tb \
	&& ./obj_dir/Vmpu_periph_tb 2>&1 | tee sim.log \
	|| { echo "build or simulation aborted"; exit 1; }

grep -q '\*\*\* FAILED \*\*\*' sim.log \
	&& { echo "simulation reported failure"; exit 1; } \
	|| { echo "simulation clean"; exit 0; }

// ==== sim/mpu_periph_props.sv ====
`timescale 1ns/1ps

module mpu_periph_props (
	input logic                             clk_i,
	input logic                             rst_i,
	input logic                             ack_o,
	input logic                             err_o,
	input logic                             irq_o,
	input mpu_pkg::cause_t                  cause_o,
	input logic [mpu_pkg::PIC_SOURCES-1:0]  en_mask
);
	import mpu_pkg::*;

	logic [PIC_SOURCES-1:0] en_d;	// mask the encoder used for the current irq_o

	always_ff @(posedge clk_i)
		en_d <= en_mask;

	// ==================================================
	// bus responses
	// ==================================================
	resp_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_o && err_o))
		else $error("ack_o and err_o high in the same cycle");

	ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o)
		else $error("ack_o held longer than one cycle");

	// interrupt never rises on a masked source
	irq_en: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(irq_o) |-> en_d[cause_o])
		else $error("irq_o rose with cause_o on a disabled source");

endmodule

bind mpu_periph mpu_periph_props props_inst (
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.ack_o   (ack_o),
	.err_o   (err_o),
	.irq_o   (irq_o),
	.cause_o (cause_o),
	.en_mask (upic1.en_q)
);

// ==== sim/mpu_periph_tb.sv ====
`timescale 1ns/1ps

module mpu_periph_tb;
	import mpu_pkg::*;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_PULSE, OP_WAIT, OP_ERR, OP_TMR} op_t;

	typedef struct packed {
		op_t      op;
		int       test;
		wb_adr_t  adr;
		wb_word_t data;		// write data, irq pin or wait bound
		wb_word_t exp;		// read value, valid bit + cause for a wait, or timer mask
		wb_word_t mask;		// bits compared on a read
	} row_t;

	localparam int       N_TESTS  = 6;
	localparam int       RST_CYC  = 16;
	localparam int       BUS_MAX  = 8;		// cycles before an access counts as lost
	localparam wb_word_t R        = 32'd15;	// timer reload, period is R+1
	localparam wb_word_t WAIT_MAX = R + 8;
	localparam wb_word_t VALID    = 32'h8000_0000;
	localparam wb_word_t ALL      = 32'hFFFF_FFFF;

	logic                       clk_i;
	logic                       rst_i;
	logic                       cyc_i;
	logic                       stb_i;
	logic                       we_i;
	wb_adr_t                    adr_i;
	wb_word_t                   dat_i;
	logic [PIC_EXT_SOURCES-1:0] irq_i;
	wb_word_t                   dat_o;
	logic                       ack_o;
	logic                       err_o;
	logic                       irq_o;
	cause_t                     cause_o;
	logic [PIT_CHANNELS-1:0]    tmr_o;

	row_t        rows [$];
	string       test_name [N_TESTS] = '{"register readback", "unmapped address",
		"external interrupt", "priority", "auto-reload timer", "one-shot timer"};
	int          errors;
	int          checks;
	int          cycles;
	int          limit;		// 0 until the table is built
	int          cur_test;
	int          first_err;
	int          failed_tests;
	logic [31:0] seed;
	logic [PIT_CHANNELS-1:0] tmr_seen;	// channels that pulsed since the last timer row

	mpu_periph mpu_periph_inst (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// ==================================================
	// helpers
	// ==================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic wb_adr_t pit_adr(input int ch, input wb_ofs_t r);
		wb_ofs_t o;
		o = wb_ofs_t'(ch) * PIT_CH_STRIDE + r;	// group base + register
		return {PIT_PAGE, o};
	endfunction

	function automatic wb_adr_t pic_adr(input wb_ofs_t r);
		return {PIC_PAGE, r};
	endfunction

	task automatic add_row(input op_t op, input wb_adr_t adr, input wb_word_t data,
			input wb_word_t exp, input wb_word_t mask);
		row_t r;
		r.op   = op;
		r.test = cur_test;
		r.adr  = adr;
		r.data = data;
		r.exp  = exp;
		r.mask = mask;
		rows.push_back(r);
	endtask

	task automatic check_word(input string name, input wb_word_t got, input wb_word_t exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cause(input string name, input cause_t got, input cause_t exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_tmr(input string name, input logic [PIT_CHANNELS-1:0] got,
			input logic [PIT_CHANNELS-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// ==================================================
	// bus access, starts and ends on a falling edge
	// ==================================================
	task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_word_t dat,
			output logic got_ack, output logic got_err, output wb_word_t rd);
		int lat;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = we;
		adr_i = adr;
		dat_i = dat;
		lat   = 0;
		do begin
			@(negedge clk_i);
			lat++;
		end while (!ack_o && !err_o && lat < BUS_MAX);
		got_ack = ack_o;
		got_err = err_o;
		rd      = dat_o;		// dat_o only valid with the response
		if (!ack_o && !err_o) begin
			$display("no bus response at address %h after %0d cycles", adr, lat);
			errors++;
		end else if (lat != 1) begin
			$display("mismatch response latency: got %h, expected %h", lat, 1);
			errors++;
		end
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		@(negedge clk_i);		// idle cycle so the next strobe is a fresh one
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_word_t dat,
			output logic got_ack, output logic got_err);
		wb_word_t unused;
		bus_cycle(1'b1, adr, dat, got_ack, got_err, unused);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_word_t rd,
			output logic got_ack, output logic got_err);
		bus_cycle(1'b0, adr, '0, got_ack, got_err, rd);
	endtask

	// ==================================================
	// stimulus table
	// ==================================================
	task automatic build_table();
		cur_test = 0;		// random words read back as written
		seed = xorshift32(seed);
		add_row(OP_WR, pic_adr(PIC_REG_ENABLE), seed, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_ENABLE), '0, seed, ALL);
		for (int ch = 0; ch < PIT_CHANNELS; ch++) begin
			seed = xorshift32(seed);
			add_row(OP_WR, pit_adr(ch, PIT_REG_RELOAD), seed, '0, '0);
			add_row(OP_RD, pit_adr(ch, PIT_REG_RELOAD), '0, seed, ALL);
		end
		cur_test = 1;
		add_row(OP_ERR, 32'h1234_5600, '0, '0, ALL);
		add_row(OP_ERR, 32'hFFDC_1000, '0, '0, ALL);	// page next to the timer
		cur_test = 2;		// pin 5 enabled, pin 9 masked
		add_row(OP_WR, pic_adr(PIC_REG_ENABLE), 32'h1 << 5, '0, '0);
		add_row(OP_PULSE, '0, 32'd5, '0, '0);
		add_row(OP_WAIT, '0, WAIT_MAX, VALID | 32'd5, '0);
		add_row(OP_RD, pic_adr(PIC_REG_CAUSE), '0, VALID | 32'd5, ALL);
		add_row(OP_WR, pic_adr(PIC_REG_CLEAR), 32'd5, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_CAUSE), '0, '0, ALL);
		add_row(OP_PULSE, '0, 32'd9, '0, '0);
		add_row(OP_WAIT, '0, WAIT_MAX, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_PENDING), '0, 32'h1 << 9, ALL);
		add_row(OP_WR, pic_adr(PIC_REG_CLEAR), 32'd9, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_PENDING), '0, '0, ALL);
		cur_test = 3;		// 17 outranks 3
		add_row(OP_WR, pic_adr(PIC_REG_ENABLE), (32'h1 << 3) | (32'h1 << 17), '0, '0);
		add_row(OP_PULSE, '0, 32'd3, '0, '0);
		add_row(OP_PULSE, '0, 32'd17, '0, '0);
		add_row(OP_WAIT, '0, WAIT_MAX, VALID | 32'd17, '0);
		add_row(OP_WR, pic_adr(PIC_REG_CLEAR), 32'd17, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_CAUSE), '0, VALID | 32'd3, ALL);
		add_row(OP_WR, pic_adr(PIC_REG_CLEAR), 32'd3, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_CAUSE), '0, '0, ALL);
		cur_test = 4;		// channel 0 lands on source 31
		add_row(OP_WR, pic_adr(PIC_REG_ENABLE), 32'h1 << 31, '0, '0);
		add_row(OP_WR, pit_adr(0, PIT_REG_RELOAD), R, '0, '0);
		add_row(OP_WR, pit_adr(0, PIT_REG_CTRL), 32'h3, '0, '0);
		add_row(OP_WAIT, '0, WAIT_MAX, VALID | 32'd31, '0);
		add_row(OP_RD, pit_adr(0, PIT_REG_COUNT), '0, '0, ~R);	// count <= R
		add_row(OP_WR, pic_adr(PIC_REG_CLEAR), 32'd31, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_CAUSE), '0, '0, ALL);	// first one retired
		add_row(OP_WAIT, '0, WAIT_MAX, VALID | 32'd31, '0);
		add_row(OP_WR, pit_adr(0, PIT_REG_CTRL), '0, '0, '0);
		add_row(OP_WR, pic_adr(PIC_REG_CLEAR), 32'd31, '0, '0);
		add_row(OP_RD, pic_adr(PIC_REG_CAUSE), '0, '0, ALL);
		add_row(OP_TMR, '0, '0, 32'h1, '0);		// only timer 0 pulsed
		cur_test = 5;		// channel 2 lands on source 29
		add_row(OP_WR, pic_adr(PIC_REG_ENABLE), 32'h1 << 29, '0, '0);
		add_row(OP_WR, pit_adr(2, PIT_REG_RELOAD), R, '0, '0);
		add_row(OP_WR, pit_adr(2, PIT_REG_CTRL), 32'h1, '0, '0);
		add_row(OP_WAIT, '0, WAIT_MAX, VALID | 32'd29, '0);
		add_row(OP_RD, pit_adr(2, PIT_REG_CTRL), '0, '0, ALL);	// enable gone
		add_row(OP_WR, pic_adr(PIC_REG_CLEAR), 32'd29, '0, '0);
		add_row(OP_WAIT, '0, 2 * WAIT_MAX, '0, '0);
		add_row(OP_TMR, '0, '0, 32'h4, '0);		// only timer 2 pulsed
	endtask

	task automatic apply_row(input row_t r);
		logic     got_ack;
		logic     got_err;
		logic     seen;
		wb_word_t rd;
		int       waited;
		case (r.op)
			OP_WR: begin
				wb_write(r.adr, r.data, got_ack, got_err);
				check_flag("ack_o", got_ack, 1'b1);
				check_flag("err_o", got_err, 1'b0);
			end
			OP_RD: begin
				wb_read(r.adr, rd, got_ack, got_err);
				check_flag("ack_o", got_ack, 1'b1);
				check_word("dat_o", rd & r.mask, r.exp);
			end
			OP_ERR: begin
				wb_read(r.adr, rd, got_ack, got_err);
				check_flag("err_o", got_err, 1'b1);
				check_flag("ack_o", got_ack, 1'b0);
				check_word("dat_o", rd, r.exp);
			end
			OP_PULSE: begin
				irq_i[r.data[CAUSE_W-1:0]] = 1'b1;
				@(negedge clk_i);
				irq_i = '0;
				repeat (3) @(negedge clk_i);	// input reg, edge detect, irq reg
			end
			OP_TMR: begin
				check_tmr("tmr_o", tmr_seen, r.exp[PIT_CHANNELS-1:0]);
				tmr_seen = '0;
			end
			default: begin		// wait for irq_o, or make sure it stays low
				waited = 0;
				seen   = irq_o;
				while (!seen && waited < r.data) begin
					@(negedge clk_i);
					waited++;
					seen = irq_o;
				end
				if (!r.exp[PIC_CAUSE_VALID])
					check_flag("irq_o", seen, 1'b0);
				else if (!seen) begin
					$display("no interrupt within %0d cycles", r.data);
					errors++;
				end else
					check_cause("cause_o", cause_o, cause_t'(r.exp[CAUSE_W-1:0]));
			end
		endcase
	endtask

	// ==================================================
	// watchdog and main sequence
	// ==================================================
	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// terminal count pulses are one clock wide, so one falling edge sees each
	always @(negedge clk_i)
		tmr_seen = tmr_seen | tmr_o;

	initial begin
		rst_i        = 1'b1;
		cyc_i        = 1'b0;
		stb_i        = 1'b0;
		we_i         = 1'b0;
		adr_i        = '0;
		dat_i        = '0;
		irq_i        = '0;
		errors       = 0;
		checks       = 0;
		cycles       = 0;
		limit        = 0;
		failed_tests = 0;
		seed         = 32'd21558;
		build_table();
		limit = rows.size() * 64 + RST_CYC;
		repeat (RST_CYC) @(negedge clk_i);
		rst_i = 1'b0;
		@(negedge clk_i);
		tmr_seen = '0;		// timer outputs are settled low by now
		for (int t = 0; t < N_TESTS; t++) begin
			first_err = errors;
			foreach (rows[i])
				if (rows[i].test == t)
					apply_row(rows[i]);
			if (errors != first_err)
				failed_tests++;
			$display("test %0d %s: %s", t, test_name[t], (errors == first_err) ? "ok" : "bad");
		end
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			N_TESTS, failed_tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== source/mpu_bus_join.sv ====
`timescale 1ns/1ps

module mpu_bus_join (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  mpu_pkg::wb_adr_t   adr_i,
	input  mpu_pkg::wb_word_t  dat_i,
	output mpu_pkg::wb_word_t  dat_o,
	output logic               ack_o,
	output logic               err_o,
	mpu_wb_if.master           pit_bus,
	mpu_wb_if.master           pic_bus
);
	import mpu_pkg::*;

	wb_page_t page;
	logic     req;
	logic     hit_pit;
	logic     hit_pic;
	logic     miss;
	logic     miss_q;		// unmapped strobe already answered

	// ==================================================
	// page decode
	// ==================================================
	assign page    = adr_i[WB_ADR_W-1:WB_OFS_W];
	assign req     = cyc_i & stb_i;
	assign hit_pit = (page == PIT_PAGE);
	assign hit_pic = (page == PIC_PAGE);
	assign miss    = req & ~hit_pit & ~hit_pic;

	// only the selected slave sees a cycle
	assign pit_bus.cyc   = cyc_i & hit_pit;
	assign pit_bus.stb   = stb_i & hit_pit;
	assign pit_bus.we    = we_i;
	assign pit_bus.ofs   = adr_i[WB_OFS_W-1:0];
	assign pit_bus.dat_w = dat_i;

	assign pic_bus.cyc   = cyc_i & hit_pic;
	assign pic_bus.stb   = stb_i & hit_pic;
	assign pic_bus.we    = we_i;
	assign pic_bus.ofs   = adr_i[WB_OFS_W-1:0];
	assign pic_bus.dat_w = dat_i;

	// ==================================================
	// response merge
	// ==================================================
	assign ack_o = pit_bus.ack | pic_bus.ack;	// slaves never ack together

	always_comb begin
		if (pit_bus.ack)
			dat_o = pit_bus.dat_r;
		else if (pic_bus.ack)
			dat_o = pic_bus.dat_r;
		else
			dat_o = '0;		// also covers the error cycle
	end

	// error pulse one cycle after an unmapped strobe
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			miss_q <= 1'b0;
			err_o  <= 1'b0;
		end else begin
			miss_q <= miss;
			err_o  <= miss & ~miss_q;
		end
	end

endmodule

// ==== source/mpu_periph.sv ====
`timescale 1ns/1ps

module mpu_periph (
	input  logic                                 clk_i,
	input  logic                                 rst_i,
	input  logic                                 cyc_i,
	input  logic                                 stb_i,
	input  logic                                 we_i,
	input  mpu_pkg::wb_adr_t                     adr_i,
	input  mpu_pkg::wb_word_t                    dat_i,
	input  logic [mpu_pkg::PIC_EXT_SOURCES-1:0]  irq_i,
	output mpu_pkg::wb_word_t                    dat_o,
	output logic                                 ack_o,
	output logic                                 err_o,
	output logic                                 irq_o,
	output mpu_pkg::cause_t                      cause_o,
	output logic [mpu_pkg::PIT_CHANNELS-1:0]     tmr_o
);
	import mpu_pkg::*;

	logic [PIC_SOURCES-1:0] pic_src;	// pins low, timers on top

	mpu_wb_if pit_bus ();
	mpu_wb_if pic_bus ();

	// ==================================================
	// interrupt source vector
	// ==================================================
	assign pic_src[PIC_EXT_SOURCES-1:0] = irq_i;

	// reversed: timer 0 is source 31, timer 2 is source 29
	for (genvar n = 0; n < PIT_CHANNELS; n++) begin : g_tmr_src
		assign pic_src[PIT_SRC_BASE+n] = tmr_o[PIT_CHANNELS-1-n];
	end

	mpu_bus_join ujoin1 (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.we_i    (we_i),
		.adr_i   (adr_i),
		.dat_i   (dat_i),
		.dat_o   (dat_o),
		.ack_o   (ack_o),
		.err_o   (err_o),	// unmapped address
		.pit_bus (pit_bus.master),
		.pic_bus (pic_bus.master)
	);

	mpu_pit upit1 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus   (pit_bus.slave),
		.tmr_o (tmr_o)		// also feeds the pic
	);

	mpu_pic upic1 (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.bus     (pic_bus.slave),
		.src_i   (pic_src),
		.irq_o   (irq_o),
		.cause_o (cause_o)
	);

endmodule

// ==== source/mpu_pic.sv ====
`timescale 1ns/1ps

module mpu_pic (
	input  logic                             clk_i,
	input  logic                             rst_i,
	mpu_wb_if.slave                          bus,
	input  logic [mpu_pkg::PIC_SOURCES-1:0]  src_i,
	output logic                             irq_o,
	output mpu_pkg::cause_t                  cause_o
);
	import mpu_pkg::*;

	logic [PIC_SOURCES-1:0] src_q;		// input register
	logic [PIC_SOURCES-1:0] src_d;		// previous sample for edge detect
	logic [PIC_SOURCES-1:0] rise;
	logic [PIC_SOURCES-1:0] pend_q;
	logic [PIC_SOURCES-1:0] en_q;		// enable mask
	logic [PIC_SOURCES-1:0] act;		// pending and enabled
	logic [PIC_SOURCES-1:0] clr_mask;
	logic                   req_q;
	logic                   start;
	logic                   wr;
	logic                   any;
	cause_t                 win;
	wb_word_t               rd_word;

	assign start = bus.cyc & bus.stb & ~req_q;
	assign wr    = start & bus.we;
	assign rise  = src_q & ~src_d;
	assign act   = pend_q & en_q;

	// clear register retires the one source named in the low bits
	assign clr_mask = (wr && bus.ofs == PIC_REG_CLEAR) ?
		PIC_SOURCES'(1) << bus.dat_w[CAUSE_W-1:0] : '0;

	// ==================================================
	// priority encoder, highest source wins
	// ==================================================
	always_comb begin
		win = '0;
		any = 1'b0;
		for (int i = 0; i < PIC_SOURCES; i++) begin
			if (act[i]) begin
				win = cause_t'(i);	// later index overrides
				any = 1'b1;
			end
		end
	end

	always_comb begin
		rd_word = '0;
		case (bus.ofs)
			PIC_REG_CAUSE: begin
				rd_word[PIC_CAUSE_VALID] = irq_o;
				rd_word[CAUSE_W-1:0]     = cause_o;
			end
			PIC_REG_ENABLE:  rd_word = wb_word_t'(en_q);
			PIC_REG_PENDING: rd_word = wb_word_t'(pend_q);
			default:         rd_word = '0;	// clear reads back zero
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q   <= 1'b0;
			bus.ack <= 1'b0;
			src_q   <= '0;
			src_d   <= '0;
			pend_q  <= '0;
			en_q    <= '0;
			irq_o   <= 1'b0;
			cause_o <= '0;
		end else begin
			req_q   <= bus.cyc & bus.stb;
			bus.ack <= start;
			src_q   <= src_i;
			src_d   <= src_q;
			pend_q  <= (pend_q & ~clr_mask) | rise;	// new edge beats a clear
			if (wr && bus.ofs == PIC_REG_ENABLE)
				en_q <= bus.dat_w[PIC_SOURCES-1:0];
			irq_o   <= any;		// one cycle behind pending
			cause_o <= win;
		end
	end

	always_ff @(posedge clk_i)
		if (start && !bus.we)
			bus.dat_r <= rd_word;

endmodule

// ==== source/mpu_pit.sv ====
`timescale 1ns/1ps

module mpu_pit (
	input  logic                              clk_i,
	input  logic                              rst_i,
	mpu_wb_if.slave                           bus,
	output logic [mpu_pkg::PIT_CHANNELS-1:0]  tmr_o
);
	import mpu_pkg::*;

	wb_word_t                count_q  [PIT_CHANNELS];	// live down-counters
	wb_word_t                reload_q [PIT_CHANNELS];
	logic [PIT_CHANNELS-1:0] en_q;
	logic [PIT_CHANNELS-1:0] auto_q;
	logic [PIT_CHANNELS-1:0] tmr_q;
	logic [PIT_CHANNELS-1:0] ch_wr;		// write hits channel n
	logic [PIT_CHANNELS-1:0] zero;
	logic                    req_q;
	logic                    start;
	logic                    wr;
	wb_ofs_t                 ch_ofs;
	wb_ofs_t                 reg_ofs;
	wb_word_t                rd_word;

	// ==================================================
	// bus handshake and decode
	// ==================================================
	assign start   = bus.cyc & bus.stb & ~req_q;	// first cycle of a strobe
	assign wr      = start & bus.we;
	assign ch_ofs  = bus.ofs / PIT_CH_STRIDE;	// channel group
	assign reg_ofs = bus.ofs % PIT_CH_STRIDE;	// register inside the group

	always_comb begin
		for (int n = 0; n < PIT_CHANNELS; n++) begin
			ch_wr[n] = wr & (ch_ofs == wb_ofs_t'(n));
			zero[n]  = (count_q[n] == '0);
		end
	end

	// read mux, unmapped offsets give zero
	always_comb begin
		rd_word = '0;
		for (int n = 0; n < PIT_CHANNELS; n++) begin
			if (ch_ofs == wb_ofs_t'(n)) begin
				case (reg_ofs)
					PIT_REG_COUNT:  rd_word = count_q[n];
					PIT_REG_RELOAD: rd_word = reload_q[n];
					PIT_REG_CTRL: begin
						rd_word[PIT_CTRL_EN]   = en_q[n];
						rd_word[PIT_CTRL_AUTO] = auto_q[n];
					end
					default:        rd_word = '0;
				endcase
			end
		end
	end

	// ==================================================
	// control state
	// ==================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q   <= 1'b0;
			bus.ack <= 1'b0;
			en_q    <= '0;
			auto_q  <= '0;
			tmr_q   <= '0;
		end else begin
			req_q   <= bus.cyc & bus.stb;	// stays high until strobe drops
			bus.ack <= start;		// single pulse per strobe
			for (int n = 0; n < PIT_CHANNELS; n++) begin
				tmr_q[n] <= en_q[n] & zero[n];	// terminal count pulse
				if (ch_wr[n] && reg_ofs == PIT_REG_CTRL) begin
					en_q[n]   <= bus.dat_w[PIT_CTRL_EN];
					auto_q[n] <= bus.dat_w[PIT_CTRL_AUTO];
				end else if (en_q[n] && zero[n] && !auto_q[n])
					en_q[n] <= 1'b0;		// one-shot stops itself
			end
		end
	end

	// ==================================================
	// counters and reload values
	// ==================================================
	always_ff @(posedge clk_i) begin
		for (int n = 0; n < PIT_CHANNELS; n++) begin
			if (ch_wr[n] && reg_ofs == PIT_REG_RELOAD)
				reload_q[n] <= bus.dat_w;
			if (ch_wr[n] && reg_ofs == PIT_REG_CTRL && bus.dat_w[PIT_CTRL_EN])
				count_q[n] <= reload_q[n];	// start loads the period
			else if (ch_wr[n] && reg_ofs == PIT_REG_COUNT)
				count_q[n] <= bus.dat_w;
			else if (en_q[n]) begin
				if (!zero[n])
					count_q[n] <= count_q[n] - 1'b1;
				else if (auto_q[n])
					count_q[n] <= reload_q[n];	// period is reload+1
			end
		end
	end

	// read data captured on the ack edge
	always_ff @(posedge clk_i)
		if (start && !bus.we)
			bus.dat_r <= rd_word;

	assign tmr_o = tmr_q;

endmodule

// ==== source/mpu_pkg.sv ====
package mpu_pkg;

	// ==================================================
	// bus geometry
	// ==================================================
	localparam int WB_DAT_W = 32;
	localparam int WB_ADR_W = 32;
	localparam int WB_OFS_W = 8;				// 256 byte window per slave
	localparam int PAGE_W   = WB_ADR_W - WB_OFS_W;

	typedef logic [WB_DAT_W-1:0] wb_word_t;
	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	typedef logic [WB_OFS_W-1:0] wb_ofs_t;
	typedef logic [PAGE_W-1:0]   wb_page_t;

	localparam wb_page_t PIT_PAGE = 24'hFFDC11;	// timer at FFDC11xx
	localparam wb_page_t PIC_PAGE = 24'hFFDC0F;	// interrupt ctrl at FFDC0Fxx

	// ==================================================
	// interval timer register map
	// ==================================================
	localparam int      PIT_CHANNELS   = 3;
	localparam wb_ofs_t PIT_CH_STRIDE  = 8'h10;	// one register group per 16 bytes
	localparam wb_ofs_t PIT_REG_COUNT  = 8'h00;
	localparam wb_ofs_t PIT_REG_RELOAD = 8'h04;
	localparam wb_ofs_t PIT_REG_CTRL   = 8'h08;
	localparam int      PIT_CTRL_EN    = 0;		// ctrl bit: counter running
	localparam int      PIT_CTRL_AUTO  = 1;		// ctrl bit: reload at zero

	// ==================================================
	// interrupt controller register map
	// ==================================================
	localparam int PIC_SOURCES     = 32;
	localparam int PIC_EXT_SOURCES = 29;		// pins feed 0..28
	localparam int CAUSE_W         = $clog2(PIC_SOURCES);

	typedef logic [CAUSE_W-1:0] cause_t;

	localparam wb_ofs_t PIC_REG_CAUSE   = 8'h00;	// valid + winning source
	localparam wb_ofs_t PIC_REG_ENABLE  = 8'h04;
	localparam wb_ofs_t PIC_REG_PENDING = 8'h08;
	localparam wb_ofs_t PIC_REG_CLEAR   = 8'h0C;	// write source index to retire
	localparam int      PIC_CAUSE_VALID = 31;

	// timer output n lands on source 31-n
	localparam int PIT_SRC_BASE = 29;

endpackage

// ==== source/mpu_wb_if.sv ====
`timescale 1ns/1ps

// classic single-word handshake between the join and one slave
interface mpu_wb_if;
	import mpu_pkg::*;

	logic     cyc;		// cycle in progress, already page qualified
	logic     stb;		// strobe, held until ack
	logic     we;		// 1 = write
	wb_ofs_t  ofs;		// byte offset in the slave window
	wb_word_t dat_w;	// write data
	wb_word_t dat_r;	// read data, valid with ack
	logic     ack;		// one cycle pulse per strobe

	modport master (
		output cyc,
		output stb,
		output we,
		output ofs,
		output dat_w,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  ofs,
		input  dat_w,
		output dat_r,
		output ack
	);

endinterface

// ==== src.f ====
source/mpu_pkg.sv
source/mpu_wb_if.sv
source/mpu_pit.sv
source/mpu_pic.sv
source/mpu_bus_join.sv
source/mpu_periph.sv
sim/mpu_periph_props.sv
sim/mpu_periph_tb.sv
